// File: engine_alu_top.f
+incdir+include
source/pkg_engine_alu.sv
source/engine_alu_csr.sv
source/engine_alu_operand_stage.sv
source/engine_alu_ops_kernel.sv
source/engine_alu_result_stage.sv
source/engine_alu_top.sv
dv/engine_alu_assertions.sv
dv/engine_alu_tb.sv

// File: Makefile
# Verilator flow for the ALU stage testbench
VERILATOR ?= verilator
TOP       ?= engine_alu_tb
FILELIST  ?= engine_alu_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation finished: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the status comes from grep, so a missing pass line fails the target
run: compile
	@out="$$(./$(SIM_BIN) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/engine_alu_tb.sv
`default_nettype none

`include "engine_alu_cfg.svh"

module engine_alu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import pkg_engine_alu::*;

  localparam int AW = `ENGINE_ALU_APB_ADDR_W;
  localparam int NF = `ENGINE_ALU_NUM_FIELDS;
  // register map
  localparam logic [AW-1:0] REG_CTRL  = 'h0;
  localparam logic [AW-1:0] REG_CMD   = 'h4;
  localparam logic [AW-1:0] REG_COUNT = 'h8;
  localparam logic [AW-1:0] REG_BAD   = 'hC;
  localparam int DRIVE_DELAY = 2;
  // about 150 packets at up to 20 cycles each
  localparam int MAX_CYCLES = 4000;
  // control words with field_mask in 19:16, alu_mask in 11:8 and op in 5:0
  localparam logic [31:0] ARITH_CTRL [8] = '{
    32'h000F_0E01, 32'h000F_0201, 32'h000B_0E01, 32'h000F_0E02,
    32'h0007_0C02, 32'h000E_0E02, 32'h000F_0F00, 32'h000E_0000
  };

  logic              ap_clk;
  logic              areset;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [AW-1:0]     paddr;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              pready;
  logic              pslverr;
  logic              in_valid;
  logic              in_ready;
  memory_packet_data in_data;
  logic              out_valid;
  logic              out_ready;
  alu_response       out_data;

  logic [15:0] lfsr_state;
  // software view of the control register
  alu_config   cur_cfg;
  // last result the kernel produced in the model
  logic [63:0] model_acc;
  logic [63:0] expected_q [$];
  logic        ready_random;
  int unsigned cycles;
  int unsigned delivered;

  engine_alu_top engine_alu_top_inst (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  initial begin
    ap_clk = 1'b0;
    forever #10 ap_clk = ~ap_clk;
  end

  // fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11
  // one step per bit
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  // expected 64-bit result from the operation rules
  function automatic logic [63:0] model_alu(input memory_packet_data d, input alu_config c,
                                            input logic [63:0] prev);
    logic [63:0] f [NF];
    logic [63:0] sum;
    sum = '0;
    for (int i = 0; i < NF; i++) begin
      f[i] = c.field_mask[i] ? {32'd0, d.field[i]} : 64'd0;
    end
    // field 0 never joins the masked sum
    for (int i = 1; i < NF; i++) begin
      if (c.alu_mask[i]) begin
        sum = sum + f[i];
      end
    end
    case (c.operation)
      ALU_NOP: return f[0];
      ALU_ADD: return f[0] + sum;
      ALU_SUB: return f[0] - sum;
      ALU_MUL: return f[0] * f[1];
      ALU_ACC: return prev + sum;
      default: return 64'd0;
    endcase
  endfunction

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // every input change happens here just after the edge
  task automatic next_cycle();
    @(posedge ap_clk);
    #(DRIVE_DELAY);
    in_valid = 1'b0;
    out_ready = ready_random ? (draw_bits(2) != 0) : 1'b1;
  endtask

  task automatic apb_access(input logic wr, input logic [AW-1:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    next_cycle();
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    next_cycle();
    penable = 1'b1;
    @(negedge ap_clk);
    rdata = prdata;
    err = pslverr;
    next_cycle();
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input logic [AW-1:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, wdata, rdata, err);
    if (err) begin
      $display("APB write to 0x%0h got an error response at %0t ns", addr, $time);
      abort_run();
    end
    // the write has landed so later packets see it
    if (addr == REG_CTRL) begin
      cur_cfg.operation = type_alu_operation'(wdata[5:0]);
      cur_cfg.alu_mask = wdata[11:8];
      cur_cfg.field_mask = wdata[19:16];
    end
    if (addr == REG_CMD && wdata[0]) begin
      model_acc = '0;
    end
  endtask

  task automatic apb_read(input logic [AW-1:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b0, addr, '0, rdata, err);
    if (err) begin
      $display("APB read of 0x%0h got an error response at %0t ns", addr, $time);
      abort_run();
    end
    check_value(name, rdata, exp);
  endtask

  task automatic apb_expect_error(input logic wr, input logic [AW-1:0] addr);
    logic [31:0] rdata;
    logic        err;
    apb_access(wr, addr, 32'hFFFF_FFFF, rdata, err);
    if (!err) begin
      $display("APB access to 0x%0h was not rejected at %0t ns", addr, $time);
      abort_run();
    end
  endtask

  // offer one packet with random gaps until it is taken
  task automatic send_one(input memory_packet_data pkt);
    logic done;
    done = 1'b0;
    while (!done) begin
      next_cycle();
      in_valid = draw_bits(2) != 0;
      in_data = pkt;
      @(negedge ap_clk);
      done = in_valid && in_ready;
    end
  endtask

  task automatic send_packets(input int n);
    memory_packet_data pkt;
    for (int p = 0; p < n; p++) begin
      for (int i = 0; i < NF; i++) begin
        pkt.field[i] = draw_bits(32);
      end
      send_one(pkt);
    end
  endtask

  task automatic drain();
    while (expected_q.size() != 0) begin
      next_cycle();
    end
    // last handshake happens on this edge
    next_cycle();
  endtask

  // mid-cycle monitor where all DUT ports are settled
  always @(negedge ap_clk) begin
    logic [63:0] exp;
    if (!areset && in_valid && in_ready) begin
      exp = model_alu(in_data, cur_cfg, model_acc);
      model_acc = exp;
      expected_q.push_back(exp);
    end
    if (!areset && out_valid && out_ready) begin
      if (expected_q.size() == 0) begin
        $display("result delivered at %0t ns with no packet outstanding", $time);
        abort_run();
      end else begin
        exp = expected_q.pop_front();
        check_value("out_data.field[0]", out_data.field[0], exp[31:0]);
        check_value("out_data.field[1]", out_data.field[1], exp[63:32]);
        check_value("out_data.field[2]", out_data.field[2], 64'd0);
        check_value("out_data.field[3]", out_data.field[3], 64'd0);
        delivered++;
      end
    end
    if (engine_alu_top_inst.assertions_inst.error_count != 0) begin
      $display("a protocol assertion failed at %0t ns", $time);
      abort_run();
    end
  end

  always @(posedge ap_clk) begin
    cycles++;
    if (cycles == MAX_CYCLES) begin
      $display("timeout: test still running after %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  initial begin
    memory_packet_data big;
    lfsr_state = 16'd58892;
    areset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    in_valid = 1'b0;
    in_data = '0;
    out_ready = 1'b1;
    cur_cfg = '0;
    model_acc = '0;
    ready_random = 1'b0;
    cycles = 0;
    delivered = 0;
    repeat (2) @(posedge ap_clk);
    #(DRIVE_DELAY);
    areset = 1'b0;

    // reset state and register access
    @(negedge ap_clk);
    check_value("out_valid", out_valid, 64'd0);
    check_value("in_ready", in_ready, 64'd1);
    apb_read(REG_CTRL, 32'd0, "prdata(control)");
    apb_read(REG_COUNT, 32'd0, "prdata(count)");
    apb_write(REG_CTRL, 32'h000B_0E02);
    apb_read(REG_CTRL, 32'h000B_0E02, "prdata(control)");
    apb_expect_error(1'b0, REG_BAD);
    apb_expect_error(1'b1, REG_COUNT);

    // ADD, SUB and NOP with control rewritten while packets are in flight
    foreach (ARITH_CTRL[k]) begin
      ready_random = (k >= 3);
      apb_write(REG_CTRL, ARITH_CTRL[k]);
      send_packets(10);
    end

    // MUL with both operands near the top of the range
    apb_write(REG_CTRL, 32'h000F_0003);
    big.field[0] = 32'hFFFF_FFFF;
    big.field[1] = 32'hFFFF_FFFE;
    big.field[2] = 32'h1234_5678;
    big.field[3] = 32'h9ABC_DEF0;
    send_one(big);
    send_packets(10);

    // accumulator runs that each start from a cleared state
    drain();
    apb_write(REG_CMD, 32'd1);
    apb_write(REG_CTRL, 32'h000F_0E04);
    send_packets(12);
    drain();
    apb_write(REG_CMD, 32'd1);
    apb_write(REG_CTRL, 32'h000D_0A04);
    send_packets(8);
    // ACC right after ADD picks up the ADD result
    apb_write(REG_CTRL, 32'h000F_0E01);
    send_packets(3);
    apb_write(REG_CTRL, 32'h000F_0E04);
    send_packets(5);

    // DIV and an undefined code
    apb_write(REG_CTRL, 32'h000F_0E05);
    send_packets(6);
    apb_write(REG_CTRL, 32'h000F_0E3F);
    send_packets(6);
    drain();
    apb_read(REG_COUNT, delivered, "prdata(count)");

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/engine_alu_assertions.sv
`default_nettype none

`include "engine_alu_cfg.svh"

module engine_alu_assertions (
  input logic                        ap_clk,
  input logic                        areset,
  input logic                        psel,
  input logic                        penable,
  input logic                        pready,
  input logic                        pslverr,
  input logic                        in_valid,
  input logic                        in_ready,
  input logic                        out_valid,
  input logic                        out_ready,
  input pkg_engine_alu::alu_response out_data,
  input logic                        clear
);
  timeunit 1ns;
  timeprecision 100ps;

  // failed checks so far, polled by the testbench
  int unsigned error_count = 0;

  // output register holds under back-pressure
  hold_under_stall: assert property (@(posedge ap_clk) disable iff (areset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
  else begin
    error_count++;
    $error("out_valid or out_data changed while out_ready was low");
  end

  // in_ready is exactly the not-stalled condition
  ready_is_advance: assert property (@(posedge ap_clk) disable iff (areset)
    in_ready == (!out_valid || out_ready))
  else begin
    error_count++;
    $error("in_ready does not match the pipeline stall state");
  end

  // accepted packet with no stall behind it shows up 3 edges later
  latency_three: assert property (@(posedge ap_clk) disable iff (areset)
    ($past(in_valid && in_ready, 3) && $past(in_ready, 2) && $past(in_ready, 1))
    |-> out_valid)
  else begin
    error_count++;
    $error("result missing three cycles after an unstalled packet");
  end

  // no wait states, error only in an access phase
  apb_response: assert property (@(posedge ap_clk) disable iff (areset)
    pready && (!pslverr || (psel && penable)))
  else begin
    error_count++;
    $error("APB response outside an access phase or with wait states");
  end

  // clear is a single-cycle pulse
  clear_pulse: assert property (@(posedge ap_clk) disable iff (areset)
    clear |=> !clear)
  else begin
    error_count++;
    $error("clear stayed high for more than one cycle");
  end

endmodule

bind engine_alu_top engine_alu_assertions assertions_inst (
  .ap_clk    (ap_clk),
  .areset    (areset),
  .psel      (psel),
  .penable   (penable),
  .pready    (pready),
  .pslverr   (pslverr),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data),
  .clear     (clear)
);

`default_nettype wire

// File: source/engine_alu_top.sv
`default_nettype none

`include "engine_alu_cfg.svh"

module engine_alu_top (
  input  logic                              ap_clk,
  input  logic                              areset,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [`ENGINE_ALU_APB_ADDR_W-1:0] paddr,
  input  logic [`ENGINE_ALU_DATA_W-1:0]     pwdata,
  output logic [`ENGINE_ALU_DATA_W-1:0]     prdata,
  output logic                              pready,
  output logic                              pslverr,
  input  logic                              in_valid,
  output logic                              in_ready,
  input  pkg_engine_alu::memory_packet_data in_data,
  output logic                              out_valid,
  input  logic                              out_ready,
  output pkg_engine_alu::alu_response       out_data
);

  import pkg_engine_alu::*;

  alu_config      cfg;
  alu_request     req;
  alu_result_word res;
  logic           clear;
  logic           delivered;
  logic           advance;
  logic           req_valid;
  logic           res_valid;

  // output handshake, counted by the CSR block
  assign delivered = out_valid & out_ready;

  // accept only when the pipe moves
  assign in_ready = advance;

  engine_alu_csr csr_inst (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .delivered (delivered),
    .cfg       (cfg),
    .clear     (clear)
  );

  engine_alu_operand_stage operand_stage_inst (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .advance   (advance),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .cfg       (cfg),
    .req_valid (req_valid),
    .req       (req)
  );

  engine_alu_ops_kernel ops_kernel_inst (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .clear     (clear),
    .advance   (advance),
    .req_valid (req_valid),
    .req       (req),
    .res_valid (res_valid),
    .res       (res)
  );

  engine_alu_result_stage result_stage_inst (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .res_valid (res_valid),
    .res       (res),
    .out_ready (out_ready),
    .advance   (advance),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

`default_nettype wire

// File: source/engine_alu_result_stage.sv
`default_nettype none

`include "engine_alu_cfg.svh"

module engine_alu_result_stage (
  input  logic                           ap_clk,
  input  logic                           areset,
  input  logic                           res_valid,
  input  pkg_engine_alu::alu_result_word res,
  input  logic                           out_ready,
  output logic                           advance,
  output logic                           out_valid,
  output pkg_engine_alu::alu_response    out_data
);

  logic load;

  // output register empty or being taken
  // one signal stalls the whole pipe
  assign advance = ~out_valid | out_ready;

  // new result enters the output register
  assign load = advance & res_valid;

  // output valid
  // holds high while out_ready is low
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= res_valid;
    end
  end

  // output fields
  // low half to field 0, high half to field 1
  always_ff @(posedge ap_clk) begin
    if (load) begin
      out_data.field[0] <= res.half.lo;
      out_data.field[1] <= res.half.hi;
      // upper fields carry nothing
      for (int i = 2; i < `ENGINE_ALU_NUM_FIELDS; i++) begin
        out_data.field[i] <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/engine_alu_ops_kernel.sv
`default_nettype none

`include "engine_alu_cfg.svh"

module engine_alu_ops_kernel (
  input  logic                           ap_clk,
  input  logic                           areset,
  input  logic                           clear,
  input  logic                           advance,
  input  logic                           req_valid,
  input  pkg_engine_alu::alu_request     req,
  output logic                           res_valid,
  output pkg_engine_alu::alu_result_word res
);

  import pkg_engine_alu::*;

  localparam int WIDE_W = 2 * `ENGINE_ALU_DATA_W;

  logic [WIDE_W-1:0] field0;
  logic [WIDE_W-1:0] field1;
  logic [WIDE_W-1:0] masked_sum;
  logic [WIDE_W-1:0] acc_base;
  logic [WIDE_W-1:0] next_result;
  logic              take;

  // a new request enters the kernel
  assign take = advance & req_valid;

  // operands widened to 64 bits
  assign field0 = WIDE_W'(req.data.field[0]);
  assign field1 = WIDE_W'(req.data.field[1]);

  // sum of fields 1 to 3 under alu_mask
  // bit 0 of the mask has no effect
  always_comb begin
    masked_sum = '0;
    for (int i = 1; i < `ENGINE_ALU_NUM_FIELDS; i++) begin
      if (req.cfg.alu_mask[i]) begin
        masked_sum = masked_sum + WIDE_W'(req.data.field[i]);
      end
    end
  end

  // previous result or zero when a clear lands on the same edge
  assign acc_base = clear ? '0 : res.wide;

  // ALU
  always_comb begin
    case (req.cfg.operation)
      ALU_NOP: next_result = field0;
      ALU_ADD: next_result = field0 + masked_sum;
      // wraps modulo 2^64
      ALU_SUB: next_result = field0 - masked_sum;
      // full 32x32 product
      ALU_MUL: next_result = field0 * field1;
      // previous result plus the masked fields
      ALU_ACC: next_result = acc_base + masked_sum;
      // no divider so DIV gives zero like undefined codes
      ALU_DIV: next_result = '0;
      default: next_result = '0;
    endcase
  end

  // stage valid
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      res_valid <= 1'b0;
    end else if (advance) begin
      res_valid <= req_valid;
    end
  end

  // result register doubles as the accumulator
  // only valid requests or a clear change it
  // clear is meant for an idle pipeline
  // a held result is zeroed too
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      res.wide <= '0;
    end else if (take) begin
      res.wide <= next_result;
    end else if (clear) begin
      res.wide <= '0;
    end
  end

endmodule

`default_nettype wire

// File: source/engine_alu_operand_stage.sv
`default_nettype none

`include "engine_alu_cfg.svh"

module engine_alu_operand_stage (
  input  logic                              ap_clk,
  input  logic                              areset,
  input  logic                              advance,
  input  logic                              in_valid,
  input  pkg_engine_alu::memory_packet_data in_data,
  input  pkg_engine_alu::alu_config         cfg,
  output logic                              req_valid,
  output pkg_engine_alu::alu_request        req
);

  import pkg_engine_alu::*;

  memory_packet_data masked;
  logic              accept;

  // in_ready is advance, so this is the handshake
  assign accept = in_valid & advance;

  // zero the fields software masked out
  always_comb begin
    masked = '0;
    for (int i = 0; i < `ENGINE_ALU_NUM_FIELDS; i++) begin
      if (cfg.field_mask[i]) begin
        masked.field[i] = in_data.field[i];
      end
    end
  end

  // stage valid
  // bubbles move forward whenever the pipe advances
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      req_valid <= 1'b0;
    end else if (advance) begin
      req_valid <= in_valid;
    end
  end

  // payload
  // config sampled here, later writes do not reach this packet
  always_ff @(posedge ap_clk) begin
    if (accept) begin
      req.data <= masked;
      req.cfg  <= cfg;
    end
  end

endmodule

`default_nettype wire

// File: source/engine_alu_csr.sv
`default_nettype none

`include "engine_alu_cfg.svh"

module engine_alu_csr (
  input  logic                              ap_clk,
  input  logic                              areset,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [`ENGINE_ALU_APB_ADDR_W-1:0] paddr,
  input  logic [`ENGINE_ALU_DATA_W-1:0]     pwdata,
  output logic [`ENGINE_ALU_DATA_W-1:0]     prdata,
  output logic                              pready,
  output logic                              pslverr,
  input  logic                              delivered,
  output pkg_engine_alu::alu_config         cfg,
  output logic                              clear
);

  import pkg_engine_alu::*;

  // register map
  localparam logic [`ENGINE_ALU_APB_ADDR_W-1:0] ADDR_CTRL  = 'h0;
  localparam logic [`ENGINE_ALU_APB_ADDR_W-1:0] ADDR_CMD   = 'h4;
  localparam logic [`ENGINE_ALU_APB_ADDR_W-1:0] ADDR_COUNT = 'h8;

  // control word bit positions
  localparam int ALU_MASK_LSB   = 8;
  localparam int FIELD_MASK_LSB = 16;

  logic                          access;
  logic                          addr_ok;
  logic                          wr_ok;
  logic [`ENGINE_ALU_DATA_W-1:0] result_count;

  // access phase, no wait states
  assign access = psel & penable;
  assign pready = 1'b1;

  assign addr_ok = (paddr == ADDR_CTRL) | (paddr == ADDR_CMD) | (paddr == ADDR_COUNT);

  // counter is read only
  assign wr_ok   = access & pwrite & addr_ok & (paddr != ADDR_COUNT);
  assign pslverr = access & (~addr_ok | (pwrite & (paddr == ADDR_COUNT)));

  // control register
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      cfg <= '0;
    end else if (wr_ok && paddr == ADDR_CTRL) begin
      cfg.operation  <= type_alu_operation'(pwdata[`ENGINE_ALU_OP_W-1:0]);
      cfg.alu_mask   <= pwdata[ALU_MASK_LSB +: `ENGINE_ALU_NUM_FIELDS];
      cfg.field_mask <= pwdata[FIELD_MASK_LSB +: `ENGINE_ALU_NUM_FIELDS];
    end
  end

  // clear pulse, one cycle after the command write
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      clear <= 1'b0;
    end else begin
      clear <= wr_ok & (paddr == ADDR_CMD) & pwdata[0];
    end
  end

  // delivered results, wraps at 2^32
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      result_count <= '0;
    end else if (delivered) begin
      result_count <= result_count + 1'b1;
    end
  end

  // read mux
  always_comb begin
    prdata = '0;
    case (paddr)
      ADDR_CTRL: begin
        prdata[`ENGINE_ALU_OP_W-1:0]                        = cfg.operation;
        prdata[ALU_MASK_LSB +: `ENGINE_ALU_NUM_FIELDS]   = cfg.alu_mask;
        prdata[FIELD_MASK_LSB +: `ENGINE_ALU_NUM_FIELDS] = cfg.field_mask;
      end
      // command reads back as zero
      ADDR_COUNT: prdata = result_count;
      default:    prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/pkg_engine_alu.sv
`default_nettype none

`include "engine_alu_cfg.svh"

package pkg_engine_alu;

  // operation codes, 6 and above are undefined and give zero
  typedef enum logic [`ENGINE_ALU_OP_W-1:0] {
    ALU_NOP = 6'd0,
    ALU_ADD = 6'd1,
    ALU_SUB = 6'd2,
    ALU_MUL = 6'd3,
    ALU_ACC = 6'd4,
    ALU_DIV = 6'd5
  } type_alu_operation;

  // one packet from memory, field 0 in the low bits
  typedef struct packed {
    logic [`ENGINE_ALU_NUM_FIELDS-1:0][`ENGINE_ALU_DATA_W-1:0] field;
  } memory_packet_data;

  // software setup, captured per packet
  typedef struct packed {
    type_alu_operation                operation;
    logic [`ENGINE_ALU_NUM_FIELDS-1:0] alu_mask;
    logic [`ENGINE_ALU_NUM_FIELDS-1:0] field_mask;
  } alu_config;

  // masked packet plus the setup it was accepted with
  typedef struct packed {
    memory_packet_data data;
    alu_config         cfg;
  } alu_request;

  // halves of the wide result, low half in the low bits
  typedef struct packed {
    logic [`ENGINE_ALU_DATA_W-1:0] hi;
    logic [`ENGINE_ALU_DATA_W-1:0] lo;
  } alu_result_halves;

  // kernel result, arithmetic view or output-field view
  typedef union packed {
    logic [2*`ENGINE_ALU_DATA_W-1:0] wide;
    alu_result_halves                half;
  } alu_result_word;

  // output packet, same layout as the input packet
  typedef struct packed {
    logic [`ENGINE_ALU_NUM_FIELDS-1:0][`ENGINE_ALU_DATA_W-1:0] field;
  } alu_response;

endpackage

`default_nettype wire

// File: include/engine_alu_cfg.svh
`ifndef ENGINE_ALU_CFG_SVH
`define ENGINE_ALU_CFG_SVH

// packet geometry
// fields per memory packet
`define ENGINE_ALU_NUM_FIELDS 4

// bits per field, also the APB data width
`define ENGINE_ALU_DATA_W 32

// operation code width
`define ENGINE_ALU_OP_W 6

// APB address width
// covers 0x0, 0x4, 0x8 and the 0xC error slot
`define ENGINE_ALU_APB_ADDR_W 4

`endif
